// ==== Bender.yml ====
package:
  name: ahb_soc

sources:
  - hdl/ahb_soc_pkg.sv
  - hdl/ahb_slave_if.sv
  - hdl/ahb_interconnect.sv
  - hdl/ahb_sram.sv
  - hdl/ahb_led_port.sv
  - hdl/ahb_button_port.sv
  - hdl/ahb_soc_top.sv
  - target: test
    files:
      - dv/ahb_soc_asserts.sv
      - dv/tb_ahb_soc.sv

// ==== dv/ahb_soc_asserts.sv ====
`timescale 1ns/1ps

module ahb_soc_asserts
(
   input logic                            HCLK,
   input logic                            HRESETn,
   input logic [ahb_soc_pkg::haddr_w-1:0] haddr,
   input logic [1:0]                      htrans,
   input logic                            hwrite,
   input logic [ahb_soc_pkg::hdata_w-1:0] hrdata,
   input logic [7:0]                      led,
   input logic                            ram_sel,
   input logic                            led_sel,
   input logic                            button_sel
);
   import ahb_soc_pkg::*;

   logic [7:0] slot;
   logic       active;
   int         n_fail = 0;                   // Failed assertion count

   assign slot   = haddr[31:24];
   assign active = htrans[htrans_nonseq_bit];

   //////////////////////////////
   // Decode and read mux
   //////////////////////////////

   one_sel: assert property (@(posedge HCLK) disable iff (!HRESETn)
      $onehot0({ram_sel, led_sel, button_sel}))
      else
      begin
         n_fail = n_fail + 1;
         $error("more than one slave selected");
      end

   nomap_read: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (active && !hwrite && slot != slot_ram && slot != slot_led && slot != slot_button)
      |=> (hrdata == nomap_rdata))
      else
      begin
         n_fail = n_fail + 1;
         $error("unmapped read returned the wrong value");
      end

   // Change seen two edges after the write's address phase
   led_write_only: assert property (@(posedge HCLK) disable iff (!HRESETn)
      (led != $past(led)) |-> $past(led_sel && active && hwrite, 2))
      else
      begin
         n_fail = n_fail + 1;
         $error("led changed without an LED write");
      end

endmodule

bind ahb_soc_top ahb_soc_asserts u_asserts
(
   .HCLK       (HCLK),
   .HRESETn    (HRESETn),
   .haddr      (haddr),
   .htrans     (htrans),
   .hwrite     (hwrite),
   .hrdata     (hrdata),
   .led        (led),
   .ram_sel    (ram_bus.sel),
   .led_sel    (led_bus.sel),
   .button_sel (button_bus.sel)
);

// ==== dv/tb_ahb_soc.sv ====
`timescale 1ns/1ps

module tb_ahb_soc;
   import ahb_soc_pkg::*;

   localparam int mem_addr_w = mem_addr_w_default;
   localparam int words      = 2 ** (mem_addr_w - 2);
   localparam int max_cycles = 4000;         // Tests take about 1900 cycles

   logic               HCLK;
   logic               HRESETn;
   logic [haddr_w-1:0] haddr;
   logic [1:0]         htrans;
   logic               hwrite;
   logic [2:0]         hsize;
   logic [hdata_w-1:0] hwdata;
   logic [hdata_w-1:0] hrdata;
   logic [7:0]         led;
   logic [7:0]         button;

   // Reference model
   logic [hdata_w-1:0] ram_model [words];
   logic [7:0]         led_model;

   // Master pipeline state
   logic [hdata_w-1:0] wdata_next;           // Owed in the next data phase
   logic               ap_read;              // Read in the address phase
   logic [hdata_w-1:0] ap_expect;
   logic               dp_read;              // Read in the data phase
   logic [hdata_w-1:0] dp_expect;

   int    seed = 32'hfa9798ad;
   int    n_checks, n_errors, n_tests, err_start, cycles;
   string test_name;
   int    idx, keep_idx, t, lane;
   int    idx_q [$];
   logic [7:0] old_led;
   logic [7:0] nomap_slots [4] = '{8'h01, 8'h4F, 8'h52, 8'hFF};

   ahb_soc_top #(.mem_addr_w(mem_addr_w)) DUT
   (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .haddr   (haddr),
      .htrans  (htrans),
      .hwrite  (hwrite),
      .hsize   (hsize),
      .hwdata  (hwdata),
      .hrdata  (hrdata),
      .led     (led),
      .button  (button)
   );

   initial
   begin
      HCLK = 1'b0;
      forever #4 HCLK = ~HCLK;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////

   function automatic logic [hdata_w-1:0] expected_read(input logic [haddr_w-1:0] addr);
      ahb_addr_u a;
      a = addr;
      case (a.dec.slot)
         slot_ram:    return ram_model[a.mem.word[mem_addr_w-3:0]];
         slot_led:    return {24'h0, led_model};     // Zero-extended
         slot_button: return {24'h0, button};
         default:     return nomap_rdata;
      endcase
   endfunction

   task automatic model_write(input logic [haddr_w-1:0] addr, input logic [2:0] size,
                              input logic [hdata_w-1:0] data);
      ahb_addr_u a;
      int        n;
      int        first;
      a = addr;
      n = (size >= 3'd2) ? 4 : (1 << size);  // Bytes in the transfer
      first = int'(a.mem.lane) & ~(n - 1);   // Aligned start lane
      if (a.dec.slot == slot_led)
         led_model = data[7:0];
      else if (a.dec.slot == slot_ram)
         for (int b = first; b < first + n; b++)
            ram_model[a.mem.word[mem_addr_w-3:0]][b*8 +: 8] = data[b*8 +: 8];
   endtask

   function automatic logic [haddr_w-1:0] ram_addr(input int word, input int ln);
      ahb_addr_u a;
      a          = '0;
      a.mem.word = word[15:0];
      a.mem.lane = ln[1:0];
      return a;
   endfunction

   //////////////////////////////
   // Compare and report
   //////////////////////////////

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks = n_checks + 1;
      if (got !== exp)
      begin
         n_errors = n_errors + 1;
         $display("mismatch %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
      end
   endtask

   // Carry the address-phase expectation into the data phase
   always @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         dp_read   <= 1'b0;
         dp_expect <= '0;
      end
      else
      begin
         dp_read   <= ap_read;
         dp_expect <= ap_expect;
      end
   end

   always @(negedge HCLK)
      if (dp_read)
         check("hrdata", hrdata, dp_expect);

   always @(posedge HCLK)
   begin
      cycles = cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout: run still going after %0d cycles", max_cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // AHB-Lite master
   //////////////////////////////

   // One address phase, also the previous transfer's data phase
   task automatic xfer(input logic [haddr_w-1:0] addr, input logic wr, input logic [2:0] size,
                       input logic [hdata_w-1:0] data);
      @(posedge HCLK);
      #1;
      hwdata  = wdata_next;
      haddr   = addr;
      htrans  = 2'b10;                       // NONSEQ
      hwrite  = wr;
      hsize   = size;
      ap_read = !wr;
      if (wr)
      begin
         model_write(addr, size, data);
         wdata_next = data;
         ap_expect  = '0;
      end
      else
      begin
         ap_expect  = expected_read(addr);   // Sees any write still in flight
         wdata_next = '0;
      end
   endtask

   task automatic idle();
      @(posedge HCLK);
      #1;
      hwdata     = wdata_next;
      htrans     = 2'b00;
      hwrite     = 1'b0;
      ap_read    = 1'b0;
      wdata_next = '0;
   endtask

   task automatic apply_reset();
      @(posedge HCLK);
      #1;
      HRESETn    = 1'b0;
      htrans     = 2'b00;
      hwrite     = 1'b0;
      hwdata     = '0;
      ap_read    = 1'b0;
      wdata_next = '0;
      led_model  = 8'h00;
      repeat (4) @(posedge HCLK);
      #1;
      HRESETn = 1'b1;
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_start = n_errors;
   endtask

   task automatic end_test();
      idle();                                // Drain the pipeline
      idle();
      n_tests = n_tests + 1;
      if (n_errors == err_start)
         $display("test %0d %s: ok", n_tests, test_name);
      else
         $display("test %0d %s: %0d errors", n_tests, test_name, n_errors - err_start);
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   initial
   begin
      HRESETn    = 1'b0;
      haddr      = '0;
      htrans     = 2'b00;
      hwrite     = 1'b0;
      hsize      = 3'b010;
      hwdata     = '0;
      button     = 8'h00;
      wdata_next = '0;
      ap_read    = 1'b0;
      ap_expect  = '0;
      led_model  = 8'h00;
      n_checks   = 0;
      n_errors   = 0;
      n_tests    = 0;
      cycles     = 0;
      apply_reset();

      begin_test("reset");
      check("led", led, 8'h00);
      check("hrdata", hrdata, 32'h0);        // Quiet before any data phase
      xfer({slot_led, 24'h0}, 1'b1, 3'b010, 32'h0000_00A5);
      idle();
      idle();
      check("led", led, 8'hA5);
      apply_reset();                         // Mid-run
      check("led", led, 8'h00);
      check("hrdata", hrdata, 32'h0);
      xfer({slot_led, 24'h0}, 1'b0, 3'b010, '0);
      end_test();

      begin_test("ram_words");
      for (t = 0; t < 800; t++)
      begin
         idx = $random(seed) & (words - 1);
         idx_q.push_back(idx);
         xfer(ram_addr(idx, 0), 1'b1, 3'b010, $random(seed));
      end
      foreach (idx_q[i])
         xfer(ram_addr(idx_q[i], 0), 1'b0, 3'b010, '0);
      end_test();

      begin_test("ram_lanes");
      for (t = 0; t < 8; t++)
      begin
         idx = $random(seed) & (words - 1);
         xfer(ram_addr(idx, 0), 1'b1, 3'b010, $random(seed));
         for (lane = 0; lane < 4; lane++)
         begin
            xfer(ram_addr(idx, lane), 1'b1, 3'b000, $random(seed));
            xfer(ram_addr(idx, 0), 1'b0, 3'b010, '0);           // Forwarded read
         end
         for (lane = 0; lane < 4; lane += 2)
         begin
            xfer(ram_addr(idx, lane), 1'b1, 3'b001, $random(seed));
            xfer(ram_addr(idx, lane), 1'b0, 3'b010, '0);
         end
      end
      keep_idx = idx;
      end_test();

      begin_test("led");
      for (t = 0; t < 6; t++)
      begin
         old_led = led_model;
         xfer({slot_led, 22'h0, 2'(t % 4)}, 1'b1, 3'(t % 3), $random(seed));
         idle();                             // Data phase
         @(negedge HCLK);
         check("led", led, old_led);
         @(posedge HCLK);
         #1;
         check("led", led, led_model);       // One cycle after the address phase
         xfer({slot_led, 24'h4}, 1'b0, 3'b010, '0);
      end
      end_test();

      begin_test("button");
      for (t = 0; t < 12; t++)
      begin
         idle();                             // Last read already sampled
         button = $random(seed);
         xfer({slot_button, 24'h0}, 1'b0, 3'b010, '0);
         xfer({slot_button, 24'h8}, 1'b1, 3'b010, $random(seed));
         xfer({slot_button, 24'h0}, 1'b0, 3'b000, '0);
      end
      end_test();

      begin_test("unmapped");
      foreach (nomap_slots[i])
      begin
         xfer({nomap_slots[i], 24'h0} | ram_addr(keep_idx, 0), 1'b1, 3'b010, $random(seed));
         xfer({nomap_slots[i], 24'h0} | ram_addr(keep_idx, 0), 1'b0, 3'b010, '0);
         xfer(ram_addr(keep_idx, 0), 1'b0, 3'b010, '0);
         xfer({slot_led, 24'h0}, 1'b0, 3'b010, '0);
      end
      check("led", led, led_model);
      end_test();

      if (DUT.u_asserts.n_fail != 0)
         $display("assertions: %0d failures during the run", DUT.u_asserts.n_fail);
      n_errors = n_errors + DUT.u_asserts.n_fail;

      $display("tests %0d  checks %0d  errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== flist.f ====
hdl/ahb_soc_pkg.sv
hdl/ahb_slave_if.sv
hdl/ahb_interconnect.sv
hdl/ahb_sram.sv
hdl/ahb_led_port.sv
hdl/ahb_button_port.sv
hdl/ahb_soc_top.sv
dv/ahb_soc_asserts.sv
dv/tb_ahb_soc.sv

// ==== hdl/ahb_button_port.sv ====
`timescale 1ns/1ps

module ahb_button_port
(
   input  logic        HCLK,
   input  logic        HRESETn,
   ahb_slave_if.slave  bus,
   input  logic [7:0]  button
);
   import ahb_soc_pkg::*;

   logic       rd_req;                       // Selected read this cycle
   logic [7:0] btn_q;                        // Sampled button value

   //////////////////////////////
   // Address phase sample
   //////////////////////////////

   // Writes fall through here and are dropped
   assign rd_req = bus.sel & bus.trans_active & ~bus.write;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         btn_q <= 8'h00;
      else if (rd_req)
         btn_q <= button;                    // Held for the data phase
   end

   //////////////////////////////
   // Data phase
   //////////////////////////////

   assign bus.rdata = {{(hdata_w-8){1'b0}}, btn_q};   // Zero-extended

endmodule

// ==== hdl/ahb_interconnect.sv ====
`timescale 1ns/1ps

module ahb_interconnect
(
   input  logic                           HCLK,
   input  logic                           HRESETn,
   input  logic [ahb_soc_pkg::haddr_w-1:0] haddr,
   input  logic [1:0]                     htrans,
   input  logic                           hwrite,
   input  logic [2:0]                     hsize,
   input  logic [ahb_soc_pkg::hdata_w-1:0] hwdata,
   output logic [ahb_soc_pkg::hdata_w-1:0] hrdata,
   ahb_slave_if.fabric                    ram_bus,
   ahb_slave_if.fabric                    led_bus,
   ahb_slave_if.fabric                    button_bus
);
   import ahb_soc_pkg::*;

   // Slot codes for the data-phase mux
   localparam logic [1:0] dslot_ram    = 2'd0;
   localparam logic [1:0] dslot_led    = 2'd1;
   localparam logic [1:0] dslot_button = 2'd2;
   localparam logic [1:0] dslot_nomap  = 2'd3;

   ahb_addr_u  addr_u;                       // Decode view of HADDR
   logic       active;                       // NONSEQ/SEQ this cycle
   logic       hit_ram, hit_led, hit_button;
   logic [1:0] aslot;                        // Address-phase slot code
   logic [1:0] data_slot;                    // Registered for the data phase
   logic       started;                      // First transfer seen since reset

   assign addr_u = haddr;
   assign active = htrans[htrans_nonseq_bit];

   //////////////////////////////
   // Address decode
   //////////////////////////////

   assign hit_ram    = (addr_u.dec.slot == slot_ram);
   assign hit_led    = (addr_u.dec.slot == slot_led);
   assign hit_button = (addr_u.dec.slot == slot_button);

   always_comb
   begin
      aslot = dslot_nomap;                   // Anything else is unmapped
      if (hit_ram)
         aslot = dslot_ram;
      else if (hit_led)
         aslot = dslot_led;
      else if (hit_button)
         aslot = dslot_button;
   end

   // Fan the address phase out, slot codes are exclusive so one sel at most
   assign ram_bus.sel    = hit_ram;
   assign led_bus.sel    = hit_led;
   assign button_bus.sel = hit_button;

   assign ram_bus.addr    = addr_u;
   assign led_bus.addr    = addr_u;
   assign button_bus.addr = addr_u;

   assign ram_bus.trans_active    = active;
   assign led_bus.trans_active    = active;
   assign button_bus.trans_active = active;

   assign ram_bus.write    = hwrite;
   assign led_bus.write    = hwrite;
   assign button_bus.write = hwrite;

   assign ram_bus.size    = hsize;
   assign led_bus.size    = hsize;
   assign button_bus.size = hsize;

   // Write data is already in its data phase
   assign ram_bus.wdata    = hwdata;
   assign led_bus.wdata    = hwdata;
   assign button_bus.wdata = hwdata;

   //////////////////////////////
   // Data phase
   //////////////////////////////

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         data_slot <= dslot_nomap;
         started   <= 1'b0;
      end
      else if (active)                       // Idle keeps the last slot
      begin
         data_slot <= aslot;
         started   <= 1'b1;
      end
   end

   // Read-data mux, quiet until the first data phase
   always_comb
   begin
      case (data_slot)
         dslot_ram:    hrdata = ram_bus.rdata;
         dslot_led:    hrdata = led_bus.rdata;
         dslot_button: hrdata = button_bus.rdata;
         default:      hrdata = nomap_rdata;
      endcase
      if (!started)
         hrdata = '0;
   end

endmodule

// ==== hdl/ahb_led_port.sv ====
`timescale 1ns/1ps

module ahb_led_port
(
   input  logic        HCLK,
   input  logic        HRESETn,
   ahb_slave_if.slave  bus,
   output logic [7:0]  led
);
   import ahb_soc_pkg::*;

   logic       wr_pend;                      // Write accepted last cycle
   logic [7:0] led_q;                        // LED register

   //////////////////////////////
   // Address phase
   //////////////////////////////

   // Any size or offset in the slot hits the one register
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         wr_pend <= 1'b0;
      else
         wr_pend <= bus.sel & bus.trans_active & bus.write;
   end

   //////////////////////////////
   // Data phase
   //////////////////////////////

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         led_q <= 8'h00;                     // LEDs dark out of reset
      else if (wr_pend)
         led_q <= bus.wdata[7:0];            // Low byte only
   end

   // Read back, zero-extended
   assign bus.rdata = {{(hdata_w-8){1'b0}}, led_q};

   assign led = led_q;

endmodule

// ==== hdl/ahb_slave_if.sv ====
`timescale 1ns/1ps

// Per-slave view of the AHB-Lite system bus
interface ahb_slave_if;
   import ahb_soc_pkg::*;

   // Address phase
   logic               sel;                  // Slot decoded to this slave
   ahb_addr_u          addr;                 // Full HADDR
   logic               trans_active;         // HTRANS is NONSEQ/SEQ
   logic               write;                // HWRITE
   logic [2:0]         size;                 // HSIZE

   // Data phase
   logic [hdata_w-1:0] wdata;                // HWDATA, one cycle after addr
   logic [hdata_w-1:0] rdata;                // Slave read data

   // Interconnect side
   modport fabric
   (
      output sel,
      output addr,
      output trans_active,
      output write,
      output size,
      output wdata,
      input  rdata
   );

   // Peripheral side
   modport slave
   (
      input  sel,
      input  addr,
      input  trans_active,
      input  write,
      input  size,
      input  wdata,
      output rdata
   );

endinterface

// ==== hdl/ahb_soc_pkg.sv ====
package ahb_soc_pkg;

   //////////////////////////////
   // Bus widths
   //////////////////////////////

   parameter int haddr_w           = 32;     // HADDR width
   parameter int hdata_w           = 32;     // HWDATA / HRDATA width
   parameter int htrans_nonseq_bit = 1;      // HTRANS[1] set for NONSEQ/SEQ

   //////////////////////////////
   // Address map
   //////////////////////////////

   // Slot is HADDR[31:24]
   parameter logic [7:0] slot_ram    = 8'h00;
   parameter logic [7:0] slot_led    = 8'h50;
   parameter logic [7:0] slot_button = 8'h51;

   parameter logic [hdata_w-1:0] nomap_rdata = 32'hDEADBEEF;   // Unmapped read value

   parameter int mem_addr_w_default = 15;    // 32 KB RAM

   // One address word, two views
   typedef union packed
   {
      struct packed
      {
         logic [7:0]  slot;                  // Slave select
         logic [23:0] offset;                // Offset within the slot
      } dec;
      struct packed
      {
         logic [13:0] unused;                // Above any RAM size
         logic [15:0] word;                  // Word index
         logic [1:0]  lane;                  // Byte lane
      } mem;
   } ahb_addr_u;

endpackage

// ==== hdl/ahb_soc_top.sv ====
`timescale 1ns/1ps

module ahb_soc_top
#(
   parameter int mem_addr_w = ahb_soc_pkg::mem_addr_w_default   // RAM byte address bits
)
(
   input  logic                            HCLK,
   input  logic                            HRESETn,

   // AHB-Lite master port
   input  logic [ahb_soc_pkg::haddr_w-1:0] haddr,    // Address phase
   input  logic [1:0]                      htrans,
   input  logic                            hwrite,
   input  logic [2:0]                      hsize,
   input  logic [ahb_soc_pkg::hdata_w-1:0] hwdata,   // Data phase
   output logic [ahb_soc_pkg::hdata_w-1:0] hrdata,   // Data phase

   // Board pins
   output logic [7:0]                      led,
   input  logic [7:0]                      button
);

   //////////////////////////////
   // Per-slave buses
   //////////////////////////////

   ahb_slave_if ram_bus ();
   ahb_slave_if led_bus ();
   ahb_slave_if button_bus ();

   //////////////////////////////
   // Decoder and read mux
   //////////////////////////////

   ahb_interconnect u_interconnect
   (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .haddr      (haddr),
      .htrans     (htrans),
      .hwrite     (hwrite),
      .hsize      (hsize),
      .hwdata     (hwdata),
      .hrdata     (hrdata),
      .ram_bus    (ram_bus.fabric),
      .led_bus    (led_bus.fabric),
      .button_bus (button_bus.fabric)
   );

   //////////////////////////////
   // Slaves
   //////////////////////////////

   // Slot 0x00
   ahb_sram #(.mem_addr_w(mem_addr_w)) u_sram
   (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .bus     (ram_bus.slave)
   );

   // Slot 0x50
   ahb_led_port u_led
   (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .bus     (led_bus.slave),
      .led     (led)
   );

   // Slot 0x51
   ahb_button_port u_button
   (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .bus     (button_bus.slave),
      .button  (button)
   );

endmodule

// ==== hdl/ahb_sram.sv ====
`timescale 1ns/1ps

module ahb_sram
#(
   parameter int mem_addr_w = ahb_soc_pkg::mem_addr_w_default   // Byte address bits
)
(
   input  logic        HCLK,
   input  logic        HRESETn,
   ahb_slave_if.slave  bus
);
   import ahb_soc_pkg::*;

   localparam int idx_w = mem_addr_w - 2;    // Word index bits
   localparam int words = 2 ** idx_w;

   logic [hdata_w-1:0] mem [words];          // Storage, no reset

   logic             rd_req;                 // Selected read this cycle
   logic             wr_req;                 // Selected write this cycle
   logic [idx_w-1:0] rd_idx;                 // Address-phase word
   logic             we;                     // Write data phase pending
   logic [idx_w-1:0] wr_idx;                 // Word of the pending write
   logic [3:0]       wr_mask;                // Byte enables of the pending write
   logic [3:0]       mask_next;
   logic             fwd_hit;
   logic [hdata_w-1:0] rd_word;
   logic [hdata_w-1:0] rd_q;

   assign rd_req = bus.sel & bus.trans_active & ~bus.write;
   assign wr_req = bus.sel & bus.trans_active & bus.write;
   assign rd_idx = bus.addr.mem.word[idx_w-1:0];

   // Byte enables from HSIZE and lane
   always_comb
   begin
      casez (bus.size[1:0])
         2'b1?:   mask_next = 4'b1111;                                    // Word
         2'b01:   mask_next = bus.addr.mem.lane[1] ? 4'b1100 : 4'b0011;   // Halfword
         default: mask_next = 4'b0001 << bus.addr.mem.lane;               // Byte
      endcase
   end

   //////////////////////////////
   // Address phase capture
   //////////////////////////////

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         we <= 1'b0;
      else
         we <= wr_req;
   end

   always_ff @(posedge HCLK)
   begin
      if (wr_req)
      begin
         wr_idx  <= rd_idx;
         wr_mask <= mask_next;
      end
   end

   //////////////////////////////
   // Array and read path
   //////////////////////////////

   assign fwd_hit = we && (wr_idx == rd_idx);   // Read of the word being written

   // Merge in-flight write bytes over the array word
   always_comb
   begin
      rd_word = mem[rd_idx];
      for (int b = 0; b < 4; b++)
         if (fwd_hit && wr_mask[b])
            rd_word[b*8 +: 8] = bus.wdata[b*8 +: 8];
   end

   always_ff @(posedge HCLK)
   begin
      if (we)
         for (int b = 0; b < 4; b++)
            if (wr_mask[b])
               mem[wr_idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];   // Commit at end of data phase
      if (rd_req)
         rd_q <= rd_word;
   end

   assign bus.rdata = rd_q;

endmodule
